// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/plru_tree.sv
  - design/cache_ctrl.sv
  - design/fence_scanner.sv
  - design/mem_arbiter.sv
  - design/dcache_top.sv
  - target: test
    files:
      - tests/dcache_asserts.sv
      - tests/dcache_tb.sv

// File: dcache_top.f
design/dcache_pkg.sv
design/plru_tree.sv
design/cache_ctrl.sv
design/fence_scanner.sv
design/mem_arbiter.sv
design/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

// File: design/cache_ctrl.sv
/* Tag, valid, dirty and data arrays, hit lookup, core response and
   the miss FSM with victim writeback and line refill */

`timescale 1ns/1ps

module cache_ctrl
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Core side
  input  logic     req_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  input  word_t    wdata_i,
  output word_t    rdata_o,
  output logic     done_o,
  output logic     busy_o,
  // Replacement state
  output idx_t     plru_idx_o,
  output logic     plru_touch_o,
  output way_vec_t plru_way_o,
  input  way_vec_t victim_i,
  // Fence scanner
  input  logic     scan_busy_i,
  input  idx_t     scan_idx_i,
  input  way_idx_t scan_way_i,
  input  logic     scan_clean_i,
  output tag_t     scan_tag_o,
  output logic     scan_valid_o,
  output logic     scan_dirty_o,
  output line_t    scan_data_o,
  // Memory port towards the arbiter
  output logic     mreq_o,
  output logic     mwe_o,
  output addr_t    maddr_o,
  output line_t    mwdata_o,
  input  logic     mack_i,
  input  line_t    mrdata_i
);

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, FINISH} state_e;

  state_e state_q, state_d;

  // Storage arrays, all readable in the same cycle
  tag_t     tag_q   [NUM_SET][NUM_WAY];
  line_t    data_q  [NUM_SET][NUM_WAY];
  way_vec_t valid_q [NUM_SET];
  way_vec_t dirty_q [NUM_SET];

  // Registered core request and the chosen victim
  logic     we_q;
  addr_t    addr_q;
  word_t    wdata_q;
  way_vec_t way_q;

  // Address fields of the held request
  idx_t              req_idx;
  tag_t              req_tag;
  logic [WSEL_W-1:0] req_wsel;

  way_vec_t hit_vec;
  way_vec_t acc_way;
  logic     hit;
  logic     accept;
  logic     complete;
  logic     vic_dirty;
  line_t    acc_line;
  line_t    merged_line;
  line_t    vic_line;
  tag_t     vic_tag;

  assign req_tag  = addr_q[XLEN-1 -: TAG_W];
  assign req_idx  = addr_q[OFF_W +: IDX_W];
  assign req_wsel = addr_q[2 +: WSEL_W];

  // ==========================================================================
  // Lookup and data select
  // ==========================================================================
  always_comb begin
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = valid_q[req_idx][w] && (tag_q[req_idx][w] == req_tag);
    end
    hit = |hit_vec;
    // After a refill the target way is the recorded victim
    acc_way = (state_q == FINISH) ? way_q : hit_vec;
    acc_line = '0;
    vic_line = '0;
    vic_tag  = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (acc_way[w]) acc_line = data_q[req_idx][w];
      if (way_q[w]) begin
        vic_line = data_q[req_idx][w];
        vic_tag  = tag_q[req_idx][w];
      end
    end
    // Store word into the selected line
    merged_line = acc_line;
    merged_line[req_wsel*XLEN +: XLEN] = wdata_q;
  end

  // Victim needs a writeback only if it holds modified data
  assign vic_dirty = |(victim_i & valid_q[req_idx] & dirty_q[req_idx]);

  assign accept   = (state_q == IDLE) && req_i && !scan_busy_i;
  assign complete = ((state_q == LOOKUP) && hit) || (state_q == FINISH);

  // ==========================================================================
  // Miss FSM
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (accept) state_d = LOOKUP;
      LOOKUP: begin
        if (hit) begin
          state_d = IDLE;
        end else if (vic_dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      WRITEBACK: if (mack_i) state_d = REFILL;
      REFILL:    if (mack_i) state_d = FINISH;
      FINISH:    state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture and victim latch
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (state_q == LOOKUP) way_q <= victim_i;
  end

  // Tag and data writes on refill or store
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAY; w++) begin
      if ((state_q == REFILL) && mack_i && way_q[w]) begin
        tag_q[req_idx][w]  <= req_tag;
        data_q[req_idx][w] <= mrdata_i;
      end else if (complete && we_q && acc_way[w]) begin
        data_q[req_idx][w] <= merged_line;
      end
    end
  end

  // Valid and dirty bits, cleared at reset
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else if ((state_q == REFILL) && mack_i) begin
      valid_q[req_idx] <= valid_q[req_idx] | way_q;
      dirty_q[req_idx] <= dirty_q[req_idx] & ~way_q;
    end else if (complete && we_q) begin
      dirty_q[req_idx] <= dirty_q[req_idx] | acc_way;
    end else if (scan_clean_i) begin
      dirty_q[scan_idx_i][scan_way_i] <= 1'b0;
    end
  end

  // Core response
  assign rdata_o = acc_line[req_wsel*XLEN +: XLEN];
  assign done_o  = complete;
  assign busy_o  = (state_q != IDLE) || scan_busy_i;

  // Replacement update on every completed access
  assign plru_idx_o   = req_idx;
  assign plru_touch_o = complete;
  assign plru_way_o   = acc_way;

  // Scanner view of one way
  assign scan_tag_o   = tag_q[scan_idx_i][scan_way_i];
  assign scan_valid_o = valid_q[scan_idx_i][scan_way_i];
  assign scan_dirty_o = dirty_q[scan_idx_i][scan_way_i];
  assign scan_data_o  = data_q[scan_idx_i][scan_way_i];

  // Memory request, victim line on writeback and aligned fetch on refill
  assign mreq_o   = (state_q == WRITEBACK) || (state_q == REFILL);
  assign mwe_o    = (state_q == WRITEBACK);
  assign maddr_o  = (state_q == WRITEBACK) ? {vic_tag, req_idx, {OFF_W{1'b0}}}
                                           : {req_tag, req_idx, {OFF_W{1'b0}}};
  assign mwdata_o = vic_line;

endmodule

// File: design/dcache_pkg.sv
/* Cache geometry constants and the vector types shared by every cache block */

package dcache_pkg;

  // ==========================================================================
  // Geometry
  // ==========================================================================

  // Address and data word width
  localparam int XLEN      = 32;
  // One line holds four words
  localparam int LINE_BITS = 128;
  localparam int NUM_WAY   = 4;
  localparam int NUM_SET   = 8;

  // Derived field widths of a byte address
  localparam int IDX_W     = $clog2(NUM_SET);
  localparam int OFF_W     = $clog2(LINE_BITS / 8);
  localparam int WSEL_W    = $clog2(LINE_BITS / XLEN);
  localparam int TAG_W     = XLEN - IDX_W - OFF_W;
  localparam int WAY_IDX_W = $clog2(NUM_WAY);

  // ==========================================================================
  // Types
  // ==========================================================================

  // Byte address
  typedef logic [XLEN-1:0] addr_t;

  // Single data word as seen by the core
  typedef logic [XLEN-1:0] word_t;

  // Whole line as moved on the memory port
  typedef logic [LINE_BITS-1:0] line_t;

  // Upper address bits kept in the tag array
  typedef logic [TAG_W-1:0] tag_t;

  // Set number
  typedef logic [IDX_W-1:0] idx_t;

  // One bit per way, used one-hot for hits and victims
  typedef logic [NUM_WAY-1:0] way_vec_t;

  // Binary way number
  typedef logic [WAY_IDX_W-1:0] way_idx_t;

  // Tree pseudo-LRU bits of one set
  typedef logic [NUM_WAY-2:0] node_t;

endpackage

// File: design/dcache_top.sv
/* Data cache top level wiring controller, PLRU state, fence scanner and arbiter */

`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  input  logic  fence_i,
  output word_t rdata_o,
  output logic  done_o,
  output logic  busy_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output line_t mem_wdata_o,
  input  line_t mem_rdata_i,
  input  logic  mem_ack_i
);

  // Replacement links
  idx_t     plru_idx;
  logic     plru_touch;
  way_vec_t plru_way;
  way_vec_t victim;

  // Scanner to array links
  logic     scan_busy;
  idx_t     scan_idx;
  way_idx_t scan_way;
  logic     scan_clean;
  tag_t     scan_tag;
  logic     scan_valid;
  logic     scan_dirty;
  line_t    scan_data;

  // Client requests into the arbiter
  logic  ctrl_mreq;
  logic  ctrl_mwe;
  addr_t ctrl_maddr;
  line_t ctrl_mwdata;
  logic  ctrl_mack;
  logic  scan_mreq;
  addr_t scan_maddr;
  line_t scan_mwdata;
  logic  scan_mack;

  cache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .done_o       (done_o),
    .busy_o       (busy_o),
    .plru_idx_o   (plru_idx),
    .plru_touch_o (plru_touch),
    .plru_way_o   (plru_way),
    .victim_i     (victim),
    .scan_busy_i  (scan_busy),
    .scan_idx_i   (scan_idx),
    .scan_way_i   (scan_way),
    .scan_clean_i (scan_clean),
    .scan_tag_o   (scan_tag),
    .scan_valid_o (scan_valid),
    .scan_dirty_o (scan_dirty),
    .scan_data_o  (scan_data),
    .mreq_o       (ctrl_mreq),
    .mwe_o        (ctrl_mwe),
    .maddr_o      (ctrl_maddr),
    .mwdata_o     (ctrl_mwdata),
    .mack_i       (ctrl_mack),
    .mrdata_i     (mem_rdata_i)
  );

  plru_tree u_plru (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .idx_i    (plru_idx),
    .touch_i  (plru_touch),
    .way_i    (plru_way),
    .victim_o (victim)
  );

  fence_scanner u_scan (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fence_i      (fence_i),
    .scan_busy_o  (scan_busy),
    .scan_idx_o   (scan_idx),
    .scan_way_o   (scan_way),
    .scan_clean_o (scan_clean),
    .scan_tag_i   (scan_tag),
    .scan_valid_i (scan_valid),
    .scan_dirty_i (scan_dirty),
    .scan_data_i  (scan_data),
    .mreq_o       (scan_mreq),
    .maddr_o      (scan_maddr),
    .mwdata_o     (scan_mwdata),
    .mack_i       (scan_mack)
  );

  mem_arbiter u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_mreq_i   (ctrl_mreq),
    .ctrl_mwe_i    (ctrl_mwe),
    .ctrl_maddr_i  (ctrl_maddr),
    .ctrl_mwdata_i (ctrl_mwdata),
    .ctrl_mack_o   (ctrl_mack),
    .scan_mreq_i   (scan_mreq),
    .scan_maddr_i  (scan_maddr),
    .scan_mwdata_i (scan_mwdata),
    .scan_mack_o   (scan_mack),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_ack_i     (mem_ack_i)
  );

endmodule

// File: design/fence_scanner.sv
/* Fence FSM that walks every set and way and writes back dirty lines */

`timescale 1ns/1ps

module fence_scanner
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     fence_i,
  // Array side
  output logic     scan_busy_o,
  output idx_t     scan_idx_o,
  output way_idx_t scan_way_o,
  output logic     scan_clean_o,
  input  tag_t     scan_tag_i,
  input  logic     scan_valid_i,
  input  logic     scan_dirty_i,
  input  line_t    scan_data_i,
  // Memory side, write only
  output logic     mreq_o,
  output addr_t    maddr_o,
  output line_t    mwdata_o,
  input  logic     mack_i
);

  typedef enum logic [2:0] {IDLE, CHECK, WRITEBACK, CLEAN, NEXT, DONE} state_e;

  state_e   state_q, state_d;
  idx_t     idx_q, idx_d;
  way_idx_t way_q, way_d;

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    way_d   = way_q;
    case (state_q)
      IDLE: begin
        if (fence_i) begin
          idx_d   = '0;
          way_d   = '0;
          state_d = CHECK;
        end
      end
      // Only valid modified lines go out
      CHECK:     state_d = (scan_valid_i && scan_dirty_i) ? WRITEBACK : NEXT;
      WRITEBACK: if (mack_i) state_d = CLEAN;
      CLEAN:     state_d = NEXT;
      NEXT: begin
        if (way_q == way_idx_t'(NUM_WAY - 1)) begin
          way_d = '0;
          if (idx_q == idx_t'(NUM_SET - 1)) begin
            state_d = DONE;
          end else begin
            idx_d   = idx_q + 1'b1;
            state_d = CHECK;
          end
        end else begin
          way_d   = way_q + 1'b1;
          state_d = CHECK;
        end
      end
      // One extra busy cycle before release
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
      way_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      way_q   <= way_d;
    end
  end

  assign scan_busy_o  = (state_q != IDLE);
  assign scan_idx_o   = idx_q;
  assign scan_way_o   = way_q;
  assign scan_clean_o = (state_q == CLEAN);

  // Line address rebuilt from stored tag and current set
  assign mreq_o   = (state_q == WRITEBACK);
  assign maddr_o  = {scan_tag_i, idx_q, {OFF_W{1'b0}}};
  assign mwdata_o = scan_data_i;

endmodule

// File: design/mem_arbiter.sv
/* Lower memory port arbiter between the miss engine and the fence scanner */

`timescale 1ns/1ps

module mem_arbiter
  import dcache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // Miss engine
  input  logic  ctrl_mreq_i,
  input  logic  ctrl_mwe_i,
  input  addr_t ctrl_maddr_i,
  input  line_t ctrl_mwdata_i,
  output logic  ctrl_mack_o,
  // Fence scanner
  input  logic  scan_mreq_i,
  input  addr_t scan_maddr_i,
  input  line_t scan_mwdata_i,
  output logic  scan_mack_o,
  // Lower memory
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output line_t mem_wdata_o,
  input  logic  mem_ack_i
);

  // Owner is high when the scanner holds the port
  logic lock_q;
  logic owner_q;
  logic grant_ctrl;
  logic grant_scan;

  // Fixed priority while free, locked owner while busy
  assign grant_ctrl = lock_q ? !owner_q : ctrl_mreq_i;
  assign grant_scan = lock_q ? owner_q  : (!ctrl_mreq_i && scan_mreq_i);

  assign mem_req_o   = (grant_ctrl && ctrl_mreq_i) || (grant_scan && scan_mreq_i);
  // Scanner traffic is always a writeback
  assign mem_we_o    = grant_scan || (grant_ctrl && ctrl_mwe_i);
  assign mem_addr_o  = grant_scan ? scan_maddr_i : ctrl_maddr_i;
  assign mem_wdata_o = grant_scan ? scan_mwdata_i : ctrl_mwdata_i;

  assign ctrl_mack_o = mem_ack_i && grant_ctrl;
  assign scan_mack_o = mem_ack_i && grant_scan;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lock_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (mem_ack_i) begin
      lock_q <= 1'b0;
    end else if (!lock_q && mem_req_o) begin
      lock_q  <= 1'b1;
      owner_q <= grant_scan;
    end
  end

endmodule

// File: design/plru_tree.sv
/* Tree pseudo-LRU state per set with victim selection and access update */

`timescale 1ns/1ps

module plru_tree
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  idx_t     idx_i,
  input  logic     touch_i,
  input  way_vec_t way_i,
  output way_vec_t victim_o
);

  // One tree per set
  node_t node_q [NUM_SET];
  node_t node_cur;
  node_t node_upd;

  assign node_cur = node_q[idx_i];

  // Victim walk from the root
  // A set node bit steers toward the upper half of that subtree
  always_comb begin
    logic sel_ok;
    for (int w = 0; w < NUM_WAY; w++) begin
      sel_ok = 1'b1;
      for (int l = 0; l < WAY_IDX_W; l++) begin
        if (((w >> (WAY_IDX_W - l - 1)) & 1) == 1) begin
          sel_ok &= node_cur[(2 ** l) - 1 + (w >> (WAY_IDX_W - l))];
        end else begin
          sel_ok &= ~node_cur[(2 ** l) - 1 + (w >> (WAY_IDX_W - l))];
        end
      end
      victim_o[w] = sel_ok;
    end
  end

  // Point every node on the accessed way's path to the other subtree
  always_comb begin
    node_upd = node_cur;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (way_i[w]) begin
        for (int l = 0; l < WAY_IDX_W; l++) begin
          node_upd[(2 ** l) - 1 + (w >> (WAY_IDX_W - l))] =
            (((w >> (WAY_IDX_W - l - 1)) & 1) == 0);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        node_q[s] <= '0;
      end
    end else if (touch_i) begin
      node_q[idx_i] <= node_upd;
    end
  end

endmodule

// File: tests/dcache_asserts.sv
/* Protocol assertions on the cache top level, attached by bind */

`timescale 1ns/1ps

module dcache_asserts
  import dcache_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_i,
  input logic  done_o,
  input logic  busy_o,
  input logic  mem_req_o,
  input logic  mem_we_o,
  input addr_t mem_addr_o,
  input line_t mem_wdata_o,
  input logic  mem_ack_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Request held with stable fields until the ack cycle
  a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && $stable(mem_addr_o) &&
                                   $stable(mem_we_o) && $stable(mem_wdata_o)))
    else begin
      fail_count++;
      $error("memory request dropped or changed before ack");
    end

  // Done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else begin
      fail_count++;
      $error("done_o high two cycles in a row");
    end

  // Core obeys busy
  a_req_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_i && busy_o))
    else begin
      fail_count++;
      $error("req_i raised while busy_o high");
    end

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

// File: tests/dcache_tb.sv
/* Data cache testbench with random word traffic, a word model,
   a delayed backing line memory and the result checks */

`timescale 1ns/1ps

module dcache_tb
  import dcache_pkg::*;
;

  // ==========================================================================
  // Run length and limits
  // ==========================================================================

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_OPS      = 400;
  // Worst dirty miss covers accept, lookup, two memory accesses of up to 6 cycles and finish
  localparam int MISS_CYC     = 20;
  // Every way of a fence may need a check, a writeback, a clean and a step
  localparam int FENCE_CYC    = NUM_SET * NUM_WAY * 10;
  // Two accesses per op plus three fences and a margin
  localparam int TIMEOUT_CYC  = NUM_OPS * 2 * MISS_CYC + 3 * FENCE_CYC + 100;
  // 2 KiB window in words and in lines
  localparam int WIN_WORDS    = 512;
  localparam int WIN_LINES    = 128;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  word_t wdata_i;
  logic  fence_i;
  word_t rdata_o;
  logic  done_o;
  logic  busy_o;
  logic  mem_req_o;
  logic  mem_we_o;
  addr_t mem_addr_o;
  line_t mem_wdata_o;
  line_t mem_rdata_i;
  logic  mem_ack_i;

  // Word model and backing line memory over the 2 KiB window
  word_t model_mem [WIN_WORDS];
  line_t back_mem  [WIN_LINES];

  integer seed     = 32'h7b7976e8;
  integer dly_seed;
  int     checks     = 0;
  int     errors     = 0;
  int     mem_writes = 0;
  logic   pending;
  int     wait_cnt;

  dcache_top uut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Initial memory content
  // Odd multiplier keeps every address distinct
  function automatic word_t pattern_word(input addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h5a5a_1234;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got=%h exp=%h at %0t", name, got, exp, $time);
    end
  endtask

  // ==========================================================================
  // Lower memory responder
  // ==========================================================================

  // Memory write must match the model for all four words of the line
  task automatic serve_memory();
    int li;
    li = mem_addr_o[10:4];
    check_val("mem_addr_o offset", mem_addr_o[3:0], 32'h0);
    check_val("mem_addr_o upper", mem_addr_o[31:11], 32'h0);
    if (mem_we_o) begin
      mem_writes++;
      for (int k = 0; k < 4; k++) begin
        check_val($sformatf("mem_wdata_o word %0d", k), mem_wdata_o[k*32 +: 32],
                  model_mem[li*4 + k]);
      end
      back_mem[li] = mem_wdata_o;
    end else begin
      mem_rdata_i = back_mem[li];
    end
  endtask

  // One-cycle ack pulse after 1 to 6 cycles
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      mem_ack_i = 1'b0;
      pending   = 1'b0;
      wait_cnt  = 0;
    end else if (mem_ack_i) begin
      mem_ack_i = 1'b0;
    end else if (mem_req_o) begin
      if (!pending) begin
        pending  = 1'b1;
        wait_cnt = {$random(dly_seed)} % 6;
      end
      if (wait_cnt == 0) begin
        serve_memory();
        mem_ack_i = 1'b1;
        pending   = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  end

  // ==========================================================================
  // Core side tasks
  // ==========================================================================

  // Starts and ends on a falling edge
  // Latency counted in cycles
  task automatic run_access(input logic we, input addr_t addr, input word_t wdata,
                            output word_t rdata, output int lat);
    while (busy_o) @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    @(negedge clk_i);
    req_i = 1'b0;
    lat   = 1;
    while (!done_o) begin
      @(negedge clk_i);
      lat++;
    end
    rdata = rdata_o;
    @(negedge clk_i);
  endtask

  task automatic check_access(input logic we, input addr_t addr, input word_t wdata,
                              input bit expect_hit);
    word_t rd;
    int    lat;
    run_access(we, addr, wdata, rd, lat);
    if (we) begin
      model_mem[addr[10:2]] = wdata;
    end else begin
      check_val("rdata_o", rd, model_mem[addr[10:2]]);
    end
    if (expect_hit) check_val("done_o latency", lat, 32'd1);
  endtask

  task automatic run_fence();
    while (busy_o) @(negedge clk_i);
    fence_i = 1'b1;
    @(negedge clk_i);
    fence_i = 1'b0;
    while (busy_o) @(negedge clk_i);
  endtask

  // Backing memory must hold the model after a fence
  task automatic compare_memory();
    for (int i = 0; i < WIN_WORDS; i++) begin
      check_val($sformatf("back_mem[%h]", i * 4), back_mem[i / 4][(i % 4)*32 +: 32],
                model_mem[i]);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    addr_t a;
    logic  we;
    int    wr_before;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    fence_i     = 1'b0;
    mem_rdata_i = '0;
    mem_ack_i   = 1'b0;
    dly_seed    = ~seed;
    for (int i = 0; i < WIN_WORDS; i++) begin
      model_mem[i] = pattern_word(addr_t'(i * 4));
      back_mem[i / 4][(i % 4)*32 +: 32] = pattern_word(addr_t'(i * 4));
    end

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("done_o", done_o, 32'h0);
    check_val("busy_o", busy_o, 32'h0);
    check_val("mem_req_o", mem_req_o, 32'h0);

    for (int n = 0; n < NUM_OPS; n++) begin
      a  = addr_t'($random(seed)) & 32'h0000_07fc;
      we = 1'($random(seed));
      check_access(we, a, $random(seed), 1'b0);
      // A repeat on the same word must hit
      if (($random(seed) & 3) == 0) begin
        check_access(1'($random(seed)), a, $random(seed), 1'b1);
      end
      if (n == NUM_OPS / 2) begin
        run_fence();
        compare_memory();
      end
    end

    run_fence();
    compare_memory();
    // All lines are clean and the fence writes nothing
    wr_before = mem_writes;
    run_fence();
    check_val("fence mem writes", mem_writes - wr_before, 32'h0);

    $display("Checks: %0d  value errors: %0d  assertion errors: %0d",
             checks, errors, uut.u_asserts.fail_count);
    if (errors == 0 && uut.u_asserts.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
